// ==== source/fm_reg_pkg.sv ====
// Only the timer registers 0x24 to 0x27 are modelled and the status byte carries no ADPCM bits
`default_nettype none

package fm_reg_pkg;

    // Register numbers latched on an address cycle
    localparam logic [7:0] REG_TIMER_A_HI = 8'h24; // Timer A value bits 9..2
    localparam logic [7:0] REG_TIMER_A_LO = 8'h25; // Timer A value bits 1..0
    localparam logic [7:0] REG_TIMER_B    = 8'h26;
    localparam logic [7:0] REG_TIMER_CTL  = 8'h27;

    localparam int TIMER_A_W = 10;
    localparam int TIMER_B_W = 8;

    // Status byte layout
    localparam int STATUS_BUSY_BIT   = 7;
    localparam int STATUS_FLAG_B_BIT = 1;
    localparam int STATUS_FLAG_A_BIT = 0;

    // Fields of a write to 0x27, MSB first
    typedef struct packed {
        logic [1:0] rsvd;       // Ignored by the chip
        logic       clr_flag_b; // Pulse only
        logic       clr_flag_a;
        logic       irq_en_b;
        logic       irq_en_a;
        logic       load_b;     // Level, timer runs while high
        logic       load_a;
    } timer_ctl_t;

    // One data byte, seen either as a timer reload or as control fields
    typedef union packed {
        logic [7:0] raw;
        timer_ctl_t ctl;
    } reg_data_u;

    typedef logic [7:0] status_t;

endpackage

`default_nettype wire

// ==== source/fm_timing_pkg.sv ====
// Ratios assume cen marks the CPU clock rate that the original chip divides by 6 then 24
`default_nettype none

package fm_timing_pkg;

    localparam int CEN_DIV          = 6;  // cen cycles per clk_en
    localparam int TICK_DIV         = 24; // clk_en pulses per sample tick
    localparam int TIMER_B_PRESCALE = 16; // Ticks per Timer B count
    localparam int BUSY_TICKS       = 32; // clk_en pulses of busy after a data write

    localparam int CEN_CNT_W  = $clog2(CEN_DIV);
    localparam int TICK_CNT_W = $clog2(TICK_DIV);
    localparam int BUSY_CNT_W = $clog2(BUSY_TICKS + 1);

    // Terminal counts, sized for direct compare
    localparam logic [CEN_CNT_W-1:0]  CEN_LAST  = CEN_CNT_W'(CEN_DIV - 1);
    localparam logic [TICK_CNT_W-1:0] TICK_LAST = TICK_CNT_W'(TICK_DIV - 1);
    localparam logic [BUSY_CNT_W-1:0] BUSY_LOAD = BUSY_CNT_W'(BUSY_TICKS);

endpackage

`default_nettype wire

// ==== source/fm_clk_gen.sv ====
// Divider phase starts at reset release and only advances while cen is high
`default_nettype none

module fm_clk_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic cen,
    output logic clk_en,
    output logic tick
);

    logic [fm_timing_pkg::CEN_CNT_W-1:0]  cen_cnt;
    logic [fm_timing_pkg::TICK_CNT_W-1:0] tick_cnt;
    logic                                 en_next;

    assign en_next = cen && (cen_cnt == fm_timing_pkg::CEN_LAST); // Last cen cycle of a group

    // CPU clock down to the operator rate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_cnt <= '0;
            clk_en  <= 1'b0;
        end else begin
            clk_en <= en_next;
            if (cen) begin
                cen_cnt <= en_next ? '0 : cen_cnt + 1'b1;
            end
        end
    end

    // Operator rate down to the sample rate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= en_next && (tick_cnt == fm_timing_pkg::TICK_LAST); // Same cycle as clk_en
            if (en_next) begin
                if (tick_cnt == fm_timing_pkg::TICK_LAST)
                    tick_cnt <= '0;
                else
                    tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fm_timer.sv ====
// Counts only while load is high and the first overflow after load may be up to one tick early
`default_nettype none

module fm_timer #(
    parameter int WIDTH    = 10,
    parameter int PRESCALE = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tick,
    input  logic [WIDTH-1:0] value,
    input  logic             load,
    input  logic             irq_en,
    input  logic             clr_flag,
    output logic             flag
);

    localparam int               PRE_W    = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(PRESCALE - 1);

    logic [PRE_W-1:0] pre;
    logic [WIDTH-1:0] cnt;
    logic             load_q;
    logic             load_rise;
    logic             step;
    logic             adv;
    logic             ovf;

    assign load_rise = load && !load_q;
    assign step      = load && !load_rise && tick;
    assign adv       = step && (pre == PRE_LAST); // Prescaler wraps
    assign ovf       = adv && (&cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b0;
            pre    <= '0;
            cnt    <= '0;
        end else begin
            load_q <= load;
            if (load_rise) begin
                cnt <= value;  // Fresh start on every load edge
                pre <= '0;
            end else if (step) begin
                if (adv) begin
                    pre <= '0;
                    cnt <= ovf ? value : cnt + 1'b1;
                end else begin
                    pre <= pre + 1'b1;
                end
            end
        end
    end

    // Sticky overflow flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            flag <= 1'b0;
        else if (clr_flag)
            flag <= 1'b0;      // Clear beats a same-cycle overflow
        else if (ovf && irq_en)
            flag <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== source/fm_bus_if.sv ====
// Writes are taken every cycle with cs_n and wr_n low even while busy, and no read mux exists
`default_nettype none

module fm_bus_if (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clk_en,
    input  logic [7:0]                       din,
    input  logic                             addr,
    input  logic                             cs_n,
    input  logic                             wr_n,
    input  logic                             flag_a,
    input  logic                             flag_b,
    output logic [fm_reg_pkg::TIMER_A_W-1:0] value_a,
    output logic [fm_reg_pkg::TIMER_B_W-1:0] value_b,
    output logic                             load_a,
    output logic                             load_b,
    output logic                             irq_en_a,
    output logic                             irq_en_b,
    output logic                             clr_flag_a,
    output logic                             clr_flag_b,
    output fm_reg_pkg::status_t              dout,
    output logic                             irq_n
);

    logic                                 write;
    logic                                 addr_wr;
    logic                                 data_wr;
    logic                                 ctl_wr;
    logic [7:0]                           reg_num;
    fm_reg_pkg::reg_data_u                data;
    logic [fm_timing_pkg::BUSY_CNT_W-1:0] busy_cnt;
    logic                                 busy;
    fm_reg_pkg::status_t                  status;

    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && !addr;
    assign data_wr = write && addr;
    assign ctl_wr  = data_wr && (reg_num == fm_reg_pkg::REG_TIMER_CTL);
    assign data    = din; // Decoded as raw or as control fields

    // Flag clears act on the write cycle itself
    assign clr_flag_a = ctl_wr && data.ctl.clr_flag_a;
    assign clr_flag_b = ctl_wr && data.ctl.clr_flag_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_num  <= '0;
            load_a   <= 1'b0;
            load_b   <= 1'b0;
            irq_en_a <= 1'b0;
            irq_en_b <= 1'b0;
        end else begin
            if (addr_wr)
                reg_num <= data.raw;
            if (ctl_wr) begin
                load_a   <= data.ctl.load_a;
                load_b   <= data.ctl.load_b;
                irq_en_a <= data.ctl.irq_en_a;
                irq_en_b <= data.ctl.irq_en_b;
            end
        end
    end

    // Reload values
    always_ff @(posedge clk) begin
        if (data_wr) begin
            case (reg_num)
                fm_reg_pkg::REG_TIMER_A_HI: value_a[fm_reg_pkg::TIMER_A_W-1:2] <= data.raw;
                fm_reg_pkg::REG_TIMER_A_LO: value_a[1:0] <= data.raw[1:0];
                fm_reg_pkg::REG_TIMER_B:    value_b <= data.raw;
                default: ;                  // Other registers are not modelled
            endcase
        end
    end

    // Busy counts clk_en pulses after any data write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            busy_cnt <= '0;
        else if (data_wr)
            busy_cnt <= fm_timing_pkg::BUSY_LOAD;
        else if (clk_en && busy)
            busy_cnt <= busy_cnt - 1'b1;
    end

    assign busy = |busy_cnt;

    always_comb begin
        status = '0;
        status[fm_reg_pkg::STATUS_BUSY_BIT]   = busy;
        status[fm_reg_pkg::STATUS_FLAG_B_BIT] = flag_b;
        status[fm_reg_pkg::STATUS_FLAG_A_BIT] = flag_a;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout  <= '0;
            irq_n <= 1'b1;
        end else begin
            dout  <= status;
            irq_n <= !(flag_a || flag_b); // Flags only set with their irq enabled
        end
    end

endmodule

`default_nettype wire

// ==== source/fm_ctrl_top.sv ====
// Timer and status section only, so cen must stay high for the nominal timer periods
`default_nettype none

module fm_ctrl_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  logic [7:0]          din,
    input  logic                addr,
    input  logic                cs_n,
    input  logic                wr_n,
    output fm_reg_pkg::status_t dout,
    output logic                irq_n
);

    logic                             clk_en;
    logic                             tick;
    logic [fm_reg_pkg::TIMER_A_W-1:0] value_a;
    logic [fm_reg_pkg::TIMER_B_W-1:0] value_b;
    logic                             load_a, load_b;
    logic                             irq_en_a, irq_en_b;
    logic                             clr_flag_a, clr_flag_b;
    logic                             flag_a, flag_b;

    fm_clk_gen clk_gen_i (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .cen    ( cen    ),
        .clk_en ( clk_en ),
        .tick   ( tick   )
    );

    fm_bus_if bus_if_i (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .clk_en     ( clk_en     ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .flag_a     ( flag_a     ),
        .flag_b     ( flag_b     ),
        .value_a    ( value_a    ),
        .value_b    ( value_b    ),
        .load_a     ( load_a     ),
        .load_b     ( load_b     ),
        .irq_en_a   ( irq_en_a   ),
        .irq_en_b   ( irq_en_b   ),
        .clr_flag_a ( clr_flag_a ),
        .clr_flag_b ( clr_flag_b ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      )
    );

    // Timer A counts every sample tick
    fm_timer #(.WIDTH(fm_reg_pkg::TIMER_A_W), .PRESCALE(1)) timer_a (
        .clk      ( clk        ),
        .rst_n    ( rst_n      ),
        .tick     ( tick       ),
        .value    ( value_a    ),
        .load     ( load_a     ),
        .irq_en   ( irq_en_a   ),
        .clr_flag ( clr_flag_a ),
        .flag     ( flag_a     )
    );

    fm_timer #(
        .WIDTH    ( fm_reg_pkg::TIMER_B_W               ),
        .PRESCALE ( fm_timing_pkg::TIMER_B_PRESCALE     )
    ) timer_b (
        .clk      ( clk        ),
        .rst_n    ( rst_n      ),
        .tick     ( tick       ),
        .value    ( value_b    ),
        .load     ( load_b     ),
        .irq_en   ( irq_en_b   ),
        .clr_flag ( clr_flag_b ),
        .flag     ( flag_b     )
    );

endmodule

`default_nettype wire

// ==== test/fm_ctrl_chk.sv ====
// Bound into every fm_bus_if, where clk_en arrives from the clock generator, assumes cen is free-running
`default_nettype none

module fm_ctrl_chk (
    input logic clk,
    input logic rst_n,
    input logic clk_en,
    input logic data_wr,
    input logic busy,
    input logic flag_a,
    input logic flag_b,
    input logic irq_n
);

    // Divider never gives back-to-back enables
    a_clk_en_single: assert property (@(posedge clk) disable iff (!rst_n) clk_en |=> !clk_en)
        else $error("clk_en high on two consecutive cycles");

    a_busy_after_write: assert property (@(posedge clk) disable iff (!rst_n) data_wr |=> busy)
        else $error("busy not set on the cycle after a data write");

    a_irq_low: assert property (@(posedge clk) disable iff (!rst_n)
        (flag_a || flag_b) |=> !irq_n)
        else $error("irq_n not low one cycle after a timer flag");

    a_irq_high: assert property (@(posedge clk) disable iff (!rst_n)
        !(flag_a || flag_b) |=> irq_n) // Registered one cycle behind the flags
        else $error("irq_n low one cycle after both flags were clear");

endmodule

bind fm_bus_if fm_ctrl_chk chk_i (
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .clk_en  ( clk_en  ),
    .data_wr ( data_wr ),
    .busy    ( busy    ),
    .flag_a  ( flag_a  ),
    .flag_b  ( flag_b  ),
    .irq_n   ( irq_n   )
);

`default_nettype wire

// ==== test/fm_ctrl_tb.sv ====
// Reads test/fm_cases.txt relative to the run directory and holds cen high, so windows assume full rate
`default_nettype none

module fm_ctrl_tb;

    localparam int MAX_CASES = 16;

    logic                clk;
    logic                rst_n;
    logic                cen;
    logic [7:0]          din;
    logic                addr;
    logic                cs_n;
    logic                wr_n;
    fm_reg_pkg::status_t dout;
    logic                irq_n;

    logic [8*20-1:0]     case_name [MAX_CASES];
    int                  case_mode [MAX_CASES]; // 0 appear in window, 1 hold, 2 hold without clear
    int                  case_nwr  [MAX_CASES];
    logic [7:0]          case_reg  [MAX_CASES][3];
    logic [7:0]          case_dat  [MAX_CASES][3];
    fm_reg_pkg::status_t case_stat [MAX_CASES];
    logic                case_irq  [MAX_CASES];
    int                  case_min  [MAX_CASES];
    int                  case_max  [MAX_CASES];
    int                  num_cases;
    int                  errors;
    int                  passed;
    int                  failed;
    int                  cycles      = 0;
    int                  cycle_limit = 0;

    fm_ctrl_top dut_i (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .cen   ( cen   ),
        .din   ( din   ),
        .addr  ( addr  ),
        .cs_n  ( cs_n  ),
        .wr_n  ( wr_n  ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit is set once the case file is read
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run stopped after %0d cycles because the cases did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_status(input fm_reg_pkg::status_t got, input fm_reg_pkg::status_t exp,
                                input string what, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("mismatch at %0t: %0s dout 0x%02h, expected 0x%02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_irq(input logic got, input logic exp, input string what, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("mismatch at %0t: %0s irq_n %0b, expected %0b", $time, what, got, exp);
            errors++;
        end
    endtask

    // Address cycle then data cycle, entered and left on a falling edge
    task automatic bus_write(input logic [7:0] num, input logic [7:0] value);
        din  = num;
        addr = 1'b0;
        cs_n = 1'b0;
        wr_n = 1'b0;
        @(negedge clk);
        din  = value;
        addr = 1'b1;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic stop_timers();
        fm_reg_pkg::reg_data_u ctl;
        ctl                = '0; // Loads and irq enables off
        ctl.ctl.clr_flag_a = 1'b1;
        ctl.ctl.clr_flag_b = 1'b1;
        bus_write(fm_reg_pkg::REG_TIMER_CTL, ctl.raw);
    endtask

    task automatic run_case(input int i);
        string               what;
        fm_reg_pkg::status_t busy_mask;
        fm_reg_pkg::status_t match_mask;
        bit                  ok_s;
        bit                  ok_i;
        bit                  good;
        bit                  seen;
        int                  n;
        int                  w;
        what      = $sformatf("%0s", case_name[i]);
        busy_mask = '0;
        busy_mask[fm_reg_pkg::STATUS_BUSY_BIT] = 1'b1;
        match_mask = '1;
        if ((case_stat[i] & ~busy_mask) != '0)
            match_mask = ~busy_mask; // A flag may arrive while busy from the writes is still high
        good      = 1'b1;
        seen      = 1'b0;
        if (case_mode[i] != 2)
            stop_timers();
        for (w = 0; w < case_nwr[i]; w++)
            bus_write(case_reg[i][w], case_dat[i][w]);
        n = 0; // Cycles since the last data write
        while (n <= case_max[i] && !seen && good) begin
            if (n == 1 && case_mode[i] != 2) begin
                check_status(dout & busy_mask, busy_mask, {what, " busy bit"}, ok_s);
                good = ok_s;
            end
            if (case_mode[i] == 0) begin
                if ((dout & match_mask) === case_stat[i] && irq_n === case_irq[i]) begin
                    seen = 1'b1;
                    if (n < case_min[i]) begin
                        $display("%0s: expected state came too early, cycle %0d before %0d",
                                 what, n, case_min[i]);
                        errors++;
                        good = 1'b0;
                    end
                end
            end else if (n >= case_min[i]) begin
                check_status(dout, case_stat[i], what, ok_s);
                check_irq(irq_n, case_irq[i], what, ok_i);
                good = ok_s && ok_i;
            end
            @(negedge clk);
            n++;
        end
        if (good && case_mode[i] == 0 && !seen) begin
            $display("%0s: timed out after %0d cycles without dout 0x%02h and irq_n %0b",
                     what, case_max[i], case_stat[i], case_irq[i]);
            errors++;
            good = 1'b0;
        end
        if (good)
            passed++;
        else
            failed++;
        $display("Test %0s %0s", what, good ? "ok" : "FAILED");
    endtask

    initial begin
        int                  fd;
        int                  code;
        int                  k;
        string               line;
        logic [8*20-1:0]     name;
        int                  mode;
        int                  nwr;
        int                  vmin;
        int                  vmax;
        logic [7:0]          r0, d0, r1, d1, r2, d2;
        fm_reg_pkg::status_t st;
        logic                irq;
        rst_n     = 1'b0;
        cen       = 1'b1;
        din       = '0;
        addr      = 1'b0;
        cs_n      = 1'b1;
        wr_n      = 1'b1;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        num_cases = 0;
        fd = $fopen("test/fm_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file test/fm_cases.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd) && num_cases < MAX_CASES) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%s %d %d %h %h %h %h %h %h %h %d %d %d",
                               name, mode, nwr, r0, d0, r1, d1, r2, d2, st, irq, vmin, vmax);
                if (code != 13) begin
                    $display("Case file line could not be parsed: %0s", line);
                    errors++;
                end else begin
                    case_name[num_cases]   = name;
                    case_mode[num_cases]   = mode;
                    case_nwr[num_cases]    = nwr;
                    case_reg[num_cases][0] = r0;
                    case_dat[num_cases][0] = d0;
                    case_reg[num_cases][1] = r1;
                    case_dat[num_cases][1] = d1;
                    case_reg[num_cases][2] = r2;
                    case_dat[num_cases][2] = d2;
                    case_stat[num_cases]   = st;
                    case_irq[num_cases]    = irq;
                    case_min[num_cases]    = vmin;
                    case_max[num_cases]    = vmax;
                    num_cases++;
                end
            end
        end
        if (fd != 0)
            $fclose(fd);
        cycle_limit = 2000;
        for (k = 0; k < num_cases; k++)
            cycle_limit = cycle_limit + case_max[k];
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (k = 0; k < num_cases; k++)
            run_case(k);
        $display("Cases %0d, passed %0d, failed %0d, check errors %0d",
                 num_cases, passed, failed, errors);
        if (errors == 0 && failed == 0 && num_cases > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/fm_cases.txt ====
# name mode nwr reg0 dat0 reg1 dat1 reg2 dat2 status irq_n earliest latest (cycles after last write)
# mode 0 waits for status and irq_n in the window, 1 holds them over it, 2 holds with no clear first
reset           2 0 00 00 00 00 00 00 00 1 0    20
busy_b_write    0 1 26 10 00 00 00 00 00 1 186  194
timer_a_1020    0 3 24 ff 25 00 27 05 01 0 430  722
clr_flag_a      0 0 00 00 00 00 00 00 00 1 186  194
timer_a_no_irq  1 3 24 ff 25 00 27 01 00 1 200  2500
timer_a_1022    0 3 24 ff 25 02 27 05 01 0 140  434
clr_flag_a_2    0 0 00 00 00 00 00 00 00 1 186  194
timer_b_254     0 2 26 fe 27 0a 00 00 02 0 4460 4756
clr_flag_b      0 0 00 00 00 00 00 00 00 1 186  194
unused_busy     0 1 30 3f 00 00 00 00 00 1 186  194
unused_no_timer 1 1 30 3f 00 00 00 00 00 1 200  1500

// ==== files.f ====
source/fm_reg_pkg.sv
source/fm_timing_pkg.sv
source/fm_clk_gen.sv
source/fm_timer.sv
source/fm_bus_if.sv
source/fm_ctrl_top.sv
test/fm_ctrl_chk.sv
test/fm_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fm_ctrl_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
